/* all.f */
+incdir+src
src/hwpe_pkg.sv
src/handshake_mux.sv
src/scale_engine.sv
src/checksum_engine.sv
src/hwpe_subsystem.sv
verification/hwpe_properties.sv
verification/tb_hwpe_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the accelerator subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_hwpe_subsystem

./obj_dir/Vtb_hwpe_subsystem 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Test run reported a failure"
  exit 1
fi

echo "Test run finished"
exit 0

/* verification/tb_hwpe_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the accelerator subsystem
// Random jobs on both engines against a behavioral memory and a model
////////////////////////////////////////////////////////////////////////////

`include "hwpe_settings.svh"

module tb_hwpe_subsystem;

  localparam int TIMEOUT = 2000;

  logic               clk;
  logic               rst_i;
  logic               hwpe_en_i;
  hwpe_pkg::sel_t     hwpe_sel_i;
  logic               cfg_req_i;
  hwpe_pkg::cfg_req_t cfg_req_data_i;
  logic               cfg_ack_o;
  hwpe_pkg::cfg_rsp_t cfg_rsp_o;
  logic               mem_req_o;
  hwpe_pkg::mem_req_t mem_req_data_o;
  logic               mem_ack_i;
  hwpe_pkg::mem_rsp_t mem_rsp_i;
  logic               busy_o;
  logic               done_evt_o;

  logic [15:0] lfsr_q = 16'd47286;
  logic [31:0] mem [256];
  logic [31:0] exp_mem [256];
  logic [31:0] exp_sum;
  int          delay_q[$];
  int          errors = 0;
  int          mem_state = 0;
  int          mem_wait = 0;
  int          mem_writes = 0;
  int          done_cnt = 0;
  int          req_edges = 0;
  logic        req_prev = 1'b0;

  hwpe_subsystem DUT (.*);

  always #5 clk = ~clk;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH time=%0t %s got=%08h exp=%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      errors++;
      $display("ERROR time=%0t %s", $time, msg);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and monitors
  ////////////////////////////////////////////////////////////////////////////

  // Four-phase target with the ack delay taken from delay_q
  always @(posedge clk) begin
    #1;
    if (rst_i) begin
      mem_ack_i = 1'b0;
      mem_state = 0;
    end else begin
      if (mem_state == 0 && mem_req_o) begin
        mem_wait  = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
        mem_state = 1;
      end
      if (mem_state == 1) begin
        if (mem_wait == 0) begin
          if (mem_req_data_o.we) begin
            mem[mem_req_data_o.addr] = mem_req_data_o.wdata;
            mem_writes++;
          end else begin
            mem_rsp_i.rdata = mem[mem_req_data_o.addr];
          end
          mem_ack_i = 1'b1;
          mem_state = 2;
        end else begin
          mem_wait--;
        end
      end else if (mem_state == 2 && !mem_req_o) begin
        mem_ack_i = 1'b0;
        mem_state = 0;
      end
    end
  end

  always @(negedge clk) begin
    if (done_evt_o) done_cnt++;
    if (mem_req_o != req_prev) req_edges++;
    req_prev = mem_req_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Configuration and job tasks
  ////////////////////////////////////////////////////////////////////////////

  // Ack follows req by exactly one cycle in both directions
  task automatic cfg_access(input logic [2:0] addr, input logic we, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int t;
    cfg_req_data_i.addr  = addr;
    cfg_req_data_i.we    = we;
    cfg_req_data_i.wdata = wdata;
    cfg_req_i            = 1'b1;
    t = 0;
    while (!cfg_ack_o && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    check_true(cfg_ack_o, "configuration ack did not rise");
    check_eq("cfg_ack_o rise latency", t, 1);
    rdata     = cfg_rsp_o.rdata;
    cfg_req_i = 1'b0;
    t = 0;
    while (cfg_ack_o && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    check_true(!cfg_ack_o, "configuration ack did not fall");
    check_eq("cfg_ack_o fall latency", t, 1);
  endtask

  task automatic cfg_write(input logic [2:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    cfg_access(addr, 1'b1, wdata, unused);
  endtask

  task automatic check_reg(input logic [2:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    cfg_access(addr, 1'b0, '0, rd);
    check_eq(name, rd, exp);
  endtask

  task automatic select_engine(input hwpe_pkg::sel_t s);
    hwpe_sel_i = s;
    @(posedge clk);
    #1;
  endtask

  // Programs the engine, updates the model and writes CTRL
  task automatic start_job(input hwpe_pkg::sel_t s, input logic [7:0] src, input logic [7:0] dst,
                           input int len, input logic [31:0] factor, input logic delays);
    logic [7:0] a;
    exp_sum = '0;
    for (int i = 0; i < len; i++) begin
      a = src + 8'(i);
      if (s == 0) exp_mem[dst + 8'(i)] = exp_mem[a] * factor;
      else exp_sum = exp_sum + exp_mem[a];
    end
    for (int i = 0; i < 2 * len; i++) delay_q.push_back(delays ? int'(rand_bits(2)) : 0);
    select_engine(s);
    cfg_write(`HWPE_REG_SRC, 32'(src));
    cfg_write(`HWPE_REG_DST, 32'(dst));
    cfg_write(`HWPE_REG_LEN, len);
    cfg_write(`HWPE_REG_FACTOR, factor);
    cfg_write(`HWPE_REG_CTRL, 32'd1);
    check_true(busy_o, "busy_o not high after job start");
  endtask

  task automatic finish_job(input hwpe_pkg::sel_t s, input int done_base, input int writes_base);
    int t;
    t = 0;
    while (busy_o && t < TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    check_true(!busy_o, "job did not finish in time");
    repeat (10) @(posedge clk);
    #1;
    check_eq("done_evt_o pulses", done_cnt - done_base, 1);
    if (s == 1) begin
      check_reg(`HWPE_REG_RESULT, exp_sum, "RESULT");
      check_eq("checksum memory writes", mem_writes - writes_base, 0);
    end
    for (int a = 0; a < 256; a++) check_eq($sformatf("mem[%0d]", a), mem[a], exp_mem[a]);
    delay_q.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          db;
    int          wb;
    int          len;
    int          edges;
    logic [31:0] f;
    hwpe_pkg::sel_t s;
    clk            = 1'b0;
    rst_i          = 1'b1;
    hwpe_en_i      = 1'b1;
    hwpe_sel_i     = '0;
    cfg_req_i      = 1'b0;
    cfg_req_data_i = '0;
    mem_ack_i      = 1'b0;
    mem_rsp_i      = '0;
    for (int a = 0; a < 256; a++) begin
      mem[a]     = rand_bits(32);
      exp_mem[a] = mem[a];
    end
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // Register readback and offsets private to each engine
    select_engine(0);
    cfg_write(`HWPE_REG_SRC, 32'h0000_0011);
    cfg_write(`HWPE_REG_FACTOR, 32'h1234_5678);
    cfg_write(3'd7, 32'h5a5a_5a5a);
    check_reg(`HWPE_REG_SRC, 32'h0000_0011, "scale SRC");
    check_reg(`HWPE_REG_FACTOR, 32'h1234_5678, "scale FACTOR");
    check_reg(3'd7, '0, "scale offset 7");
    select_engine(1);
    cfg_write(`HWPE_REG_LEN, 32'h0000_0005);
    cfg_write(`HWPE_REG_DST, 32'h0000_0099);
    check_reg(`HWPE_REG_LEN, 32'h0000_0005, "checksum LEN");
    check_reg(`HWPE_REG_FACTOR, '0, "checksum FACTOR");
    check_reg(`HWPE_REG_DST, '0, "checksum DST");

    // Busy visible in STATUS and a second CTRL write ignored
    db = done_cnt;
    wb = mem_writes;
    start_job(0, 8'd4, 8'd200, 8, 32'd3, 1'b1);
    check_reg(`HWPE_REG_STATUS, 32'd1, "STATUS during job");
    cfg_write(`HWPE_REG_CTRL, 32'd1);
    finish_job(0, db, wb);

    // Disabled engine in mid-job makes no progress
    db = done_cnt;
    wb = mem_writes;
    start_job(0, 8'd40, 8'd140, 6, 32'd7, 1'b0);
    repeat (4) @(posedge clk);
    #1;
    hwpe_en_i = 1'b0;
    @(posedge clk);
    #1;
    edges = req_edges;
    repeat (20) @(posedge clk);
    #1;
    check_eq("mem_req_o edges while disabled", req_edges - edges, 0);
    check_true(busy_o, "busy_o dropped while disabled");
    hwpe_en_i = 1'b1;
    finish_job(0, db, wb);

    // Ten random jobs with random ack delays
    for (int j = 0; j < 10; j++) begin
      s   = hwpe_pkg::sel_t'(j % 2);
      len = 1 + int'(rand_bits(3));
      f   = rand_bits(32);
      db  = done_cnt;
      wb  = mem_writes;
      start_job(s, 8'(rand_bits(6)), 8'd128 + 8'(rand_bits(6)), len, f, 1'b1);
      finish_job(s, db, wb);
    end

    $display("Checks finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #500000;
    $display("Run did not finish before the watchdog limit");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* verification/hwpe_properties.sv */
////////////////////////////////////////////////////////////////////////////
// Handshake properties of the accelerator subsystem ports
////////////////////////////////////////////////////////////////////////////

module hwpe_properties (
  input logic               clk,
  input logic               rst_i,
  input logic               cfg_req_i,
  input logic               cfg_ack_o,
  input logic               mem_req_o,
  input hwpe_pkg::mem_req_t mem_req_data_o,
  input logic               mem_ack_i,
  input logic               done_evt_o
);

  // Memory request and payload hold until the target acks
  mem_req_hold: assert property (@(posedge clk) disable iff (rst_i)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_req_data_o)))
    else $error("memory request dropped or changed before ack");

  // A new request only rises once ack is low
  mem_req_after_ack: assert property (@(posedge clk) disable iff (rst_i)
    $rose(mem_req_o) |-> !$past(mem_ack_i))
    else $error("memory request rose while ack was high");

  done_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
    done_evt_o |=> !done_evt_o)
    else $error("done event lasted more than one cycle");

  cfg_ack_follows_req: assert property (@(posedge clk) disable iff (rst_i)
    $rose(cfg_ack_o) |-> $past(cfg_req_i))
    else $error("configuration ack rose without a request");

endmodule

bind hwpe_subsystem hwpe_properties i_props (
  .clk            ( clk            ),
  .rst_i          ( rst_i          ),
  .cfg_req_i      ( cfg_req_i      ),
  .cfg_ack_o      ( cfg_ack_o      ),
  .mem_req_o      ( mem_req_o      ),
  .mem_req_data_o ( mem_req_data_o ),
  .mem_ack_i      ( mem_ack_i      ),
  .done_evt_o     ( done_evt_o     )
);

/* src/hwpe_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// Accelerator subsystem top
// Scale and checksum engines behind one configuration port and one
// memory port. The select input picks the engine both ports reach.
////////////////////////////////////////////////////////////////////////////

`include "hwpe_settings.svh"

module hwpe_subsystem (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               hwpe_en_i,
  input  hwpe_pkg::sel_t     hwpe_sel_i,
  // Configuration port
  input  logic               cfg_req_i,
  input  hwpe_pkg::cfg_req_t cfg_req_data_i,
  output logic               cfg_ack_o,
  output hwpe_pkg::cfg_rsp_t cfg_rsp_o,
  // Memory port
  output logic               mem_req_o,
  output hwpe_pkg::mem_req_t mem_req_data_o,
  input  logic               mem_ack_i,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i,
  // Status
  output logic               busy_o,
  output logic               done_evt_o
);

  localparam int unsigned N_ENG = `HWPE_N_ENGINES;

  logic [N_ENG-1:0]               eng_en;
  logic [N_ENG-1:0]               eng_cfg_req;
  logic [N_ENG-1:0]               eng_cfg_ack;
  hwpe_pkg::cfg_req_t [N_ENG-1:0] eng_cfg_data;
  hwpe_pkg::cfg_rsp_t [N_ENG-1:0] eng_cfg_rsp;
  logic [N_ENG-1:0]               eng_mem_req;
  logic [N_ENG-1:0]               eng_mem_ack;
  hwpe_pkg::mem_req_t [N_ENG-1:0] eng_mem_data;
  hwpe_pkg::mem_rsp_t [N_ENG-1:0] eng_mem_rsp;
  logic [N_ENG-1:0]               eng_busy;
  logic [N_ENG-1:0]               eng_done;

  // Unselected or disabled engines hold their state
  for (genvar i = 0; i < N_ENG; i++) begin : gen_en
    assign eng_en[i] = hwpe_en_i && (hwpe_sel_i == hwpe_pkg::sel_t'(i));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Engines
  ////////////////////////////////////////////////////////////////////////////

  scale_engine i_scale (
    .clk        ( clk             ),
    .rst_i      ( rst_i           ),
    .en_i       ( eng_en[0]       ),
    .cfg_req_i  ( eng_cfg_req[0]  ),
    .cfg_data_i ( eng_cfg_data[0] ),
    .cfg_ack_o  ( eng_cfg_ack[0]  ),
    .cfg_rsp_o  ( eng_cfg_rsp[0]  ),
    .mem_req_o  ( eng_mem_req[0]  ),
    .mem_data_o ( eng_mem_data[0] ),
    .mem_ack_i  ( eng_mem_ack[0]  ),
    .mem_rsp_i  ( eng_mem_rsp[0]  ),
    .busy_o     ( eng_busy[0]     ),
    .done_evt_o ( eng_done[0]     )
  );

  checksum_engine i_checksum (
    .clk        ( clk             ),
    .rst_i      ( rst_i           ),
    .en_i       ( eng_en[1]       ),
    .cfg_req_i  ( eng_cfg_req[1]  ),
    .cfg_data_i ( eng_cfg_data[1] ),
    .cfg_ack_o  ( eng_cfg_ack[1]  ),
    .cfg_rsp_o  ( eng_cfg_rsp[1]  ),
    .mem_req_o  ( eng_mem_req[1]  ),
    .mem_data_o ( eng_mem_data[1] ),
    .mem_ack_i  ( eng_mem_ack[1]  ),
    .mem_rsp_i  ( eng_mem_rsp[1]  ),
    .busy_o     ( eng_busy[1]     ),
    .done_evt_o ( eng_done[1]     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Channel routing
  ////////////////////////////////////////////////////////////////////////////

  // Cfg router runs the mux backwards. Engine acks and read data are
  // gathered as the array side, the outside req and request payload come
  // in on the single side and fan out to the locked engine only.
  handshake_mux #(
    .req_t ( hwpe_pkg::cfg_rsp_t ),
    .rsp_t ( hwpe_pkg::cfg_req_t ),
    .N_CH  ( N_ENG               )
  ) i_cfg_router (
    .clk        ( clk            ),
    .rst_i      ( rst_i          ),
    .sel_i      ( hwpe_sel_i     ),
    .in_req_i   ( eng_cfg_ack    ),
    .in_data_i  ( eng_cfg_rsp    ),
    .in_ack_o   ( eng_cfg_req    ),
    .in_rsp_o   ( eng_cfg_data   ),
    .out_req_o  ( cfg_ack_o      ),
    .out_data_o ( cfg_rsp_o      ),
    .out_ack_i  ( cfg_req_i      ),
    .out_rsp_i  ( cfg_req_data_i )
  );

  // Engines are memory initiators
  handshake_mux #(
    .req_t ( hwpe_pkg::mem_req_t ),
    .rsp_t ( hwpe_pkg::mem_rsp_t ),
    .N_CH  ( N_ENG               )
  ) i_mem_mux (
    .clk        ( clk            ),
    .rst_i      ( rst_i          ),
    .sel_i      ( hwpe_sel_i     ),
    .in_req_i   ( eng_mem_req    ),
    .in_data_i  ( eng_mem_data   ),
    .in_ack_o   ( eng_mem_ack    ),
    .in_rsp_o   ( eng_mem_rsp    ),
    .out_req_o  ( mem_req_o      ),
    .out_data_o ( mem_req_data_o ),
    .out_ack_i  ( mem_ack_i      ),
    .out_rsp_i  ( mem_rsp_i      )
  );

  // Status of the selected engine
  assign busy_o     = eng_busy[hwpe_sel_i];
  assign done_evt_o = eng_done[hwpe_sel_i];

endmodule

/* src/checksum_engine.sv */
////////////////////////////////////////////////////////////////////////////
// Checksum engine
// Reads LEN words from SRC and accumulates their sum modulo 2^32 into
// the RESULT register. Issues reads only.
////////////////////////////////////////////////////////////////////////////

`include "hwpe_settings.svh"

module checksum_engine (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               en_i,
  input  logic               cfg_req_i,
  input  hwpe_pkg::cfg_req_t cfg_data_i,
  output logic               cfg_ack_o,
  output hwpe_pkg::cfg_rsp_t cfg_rsp_o,
  output logic               mem_req_o,
  output hwpe_pkg::mem_req_t mem_data_o,
  input  logic               mem_ack_i,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i,
  output logic               busy_o,
  output logic               done_evt_o
);

  typedef enum logic [1:0] {
    ST_IDLE, ST_READ, ST_RD_REL, ST_DONE
  } state_t;

  state_t              state_q;
  logic [`HWPE_DW-1:0] src_q;
  logic [`HWPE_DW-1:0] len_q;
  logic [`HWPE_DW-1:0] result_q;
  logic [`HWPE_DW-1:0] idx_q;
  logic [`HWPE_DW-1:0] idx_next;
  logic [`HWPE_DW-1:0] rdata_d;
  logic                cfg_take;
  logic                start_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register slave
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_take = cfg_req_i && !cfg_ack_o;

  // DST and FACTOR do not exist here and read zero
  always_comb begin
    case (cfg_data_i.addr)
      `HWPE_REG_SRC:    rdata_d = src_q;
      `HWPE_REG_LEN:    rdata_d = len_q;
      `HWPE_REG_STATUS: rdata_d = {{(`HWPE_DW-1){1'b0}}, busy_o};
      `HWPE_REG_RESULT: rdata_d = result_q;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_ack_o <= 1'b0;
      start_q   <= 1'b0;
      src_q     <= '0;
      len_q     <= '0;
    end else if (en_i) begin
      cfg_ack_o <= cfg_req_i;
      start_q   <= cfg_take && cfg_data_i.we && (cfg_data_i.addr == `HWPE_REG_CTRL) &&
                   (state_q == ST_IDLE);
      if (cfg_take && cfg_data_i.we && state_q == ST_IDLE) begin
        case (cfg_data_i.addr)
          `HWPE_REG_SRC: src_q <= cfg_data_i.wdata;
          `HWPE_REG_LEN: len_q <= cfg_data_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en_i && cfg_take) begin
      cfg_rsp_o.rdata <= rdata_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM and accumulator
  ////////////////////////////////////////////////////////////////////////////

  assign idx_next = idx_q + `HWPE_DW'(1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      idx_q    <= '0;
      result_q <= '0;
    end else if (en_i) begin
      case (state_q)
        ST_IDLE: begin
          if (start_q) begin
            idx_q    <= '0;
            result_q <= '0;
            state_q  <= (len_q == '0) ? ST_DONE : ST_READ;
          end
        end
        ST_READ: begin
          // Sum wraps at 32 bits
          if (mem_ack_i) begin
            result_q <= result_q + mem_rsp_i.rdata;
            state_q  <= ST_RD_REL;
          end
        end
        ST_RD_REL: begin
          if (!mem_ack_i) begin
            idx_q   <= idx_next;
            state_q <= (idx_next == len_q) ? ST_DONE : ST_READ;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Memory master, reads only
  assign mem_req_o        = (state_q == ST_READ);
  assign mem_data_o.we    = 1'b0;
  assign mem_data_o.wdata = '0;
  assign mem_data_o.addr  = src_q[`HWPE_AW-1:0] + idx_q[`HWPE_AW-1:0];

  assign busy_o     = (state_q == ST_READ) || (state_q == ST_RD_REL);
  assign done_evt_o = (state_q == ST_DONE) && en_i;

endmodule

/* src/scale_engine.sv */
////////////////////////////////////////////////////////////////////////////
// Scale engine
// Reads LEN words from SRC, multiplies each by FACTOR and writes the low
// word to DST onward. One read then one write per element.
////////////////////////////////////////////////////////////////////////////

`include "hwpe_settings.svh"

module scale_engine (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               en_i,
  input  logic               cfg_req_i,
  input  hwpe_pkg::cfg_req_t cfg_data_i,
  output logic               cfg_ack_o,
  output hwpe_pkg::cfg_rsp_t cfg_rsp_o,
  output logic               mem_req_o,
  output hwpe_pkg::mem_req_t mem_data_o,
  input  logic               mem_ack_i,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i,
  output logic               busy_o,
  output logic               done_evt_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_READ, ST_RD_REL, ST_WRITE, ST_WR_REL, ST_DONE
  } state_t;

  state_t              state_q;
  logic [`HWPE_DW-1:0] src_q;
  logic [`HWPE_DW-1:0] dst_q;
  logic [`HWPE_DW-1:0] len_q;
  logic [`HWPE_DW-1:0] factor_q;
  logic [`HWPE_DW-1:0] idx_q;
  logic [`HWPE_DW-1:0] idx_next;
  logic [`HWPE_DW-1:0] data_q;
  logic [`HWPE_DW-1:0] rdata_d;
  logic                cfg_take;
  logic                start_q;

  ////////////////////////////////////////////////////////////////////////////
  // Register slave
  ////////////////////////////////////////////////////////////////////////////

  // First cycle of an access, ack rises on this edge
  assign cfg_take = cfg_req_i && !cfg_ack_o;

  always_comb begin
    case (cfg_data_i.addr)
      `HWPE_REG_SRC:    rdata_d = src_q;
      `HWPE_REG_DST:    rdata_d = dst_q;
      `HWPE_REG_LEN:    rdata_d = len_q;
      `HWPE_REG_FACTOR: rdata_d = factor_q;
      `HWPE_REG_STATUS: rdata_d = {{(`HWPE_DW-1){1'b0}}, busy_o};
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_ack_o <= 1'b0;
      start_q   <= 1'b0;
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      factor_q  <= '0;
    end else if (en_i) begin
      cfg_ack_o <= cfg_req_i;
      start_q   <= cfg_take && cfg_data_i.we && (cfg_data_i.addr == `HWPE_REG_CTRL) &&
                   (state_q == ST_IDLE);
      // Job parameters are frozen while a job runs
      if (cfg_take && cfg_data_i.we && state_q == ST_IDLE) begin
        case (cfg_data_i.addr)
          `HWPE_REG_SRC:    src_q    <= cfg_data_i.wdata;
          `HWPE_REG_DST:    dst_q    <= cfg_data_i.wdata;
          `HWPE_REG_LEN:    len_q    <= cfg_data_i.wdata;
          `HWPE_REG_FACTOR: factor_q <= cfg_data_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en_i && cfg_take) begin
      cfg_rsp_o.rdata <= rdata_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  assign idx_next = idx_q + `HWPE_DW'(1);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else if (en_i) begin
      case (state_q)
        ST_IDLE: begin
          if (start_q) begin
            idx_q   <= '0;
            state_q <= (len_q == '0) ? ST_DONE : ST_READ;
          end
        end
        ST_READ:   if (mem_ack_i) state_q <= ST_RD_REL;
        ST_RD_REL: if (!mem_ack_i) state_q <= ST_WRITE;
        ST_WRITE:  if (mem_ack_i) state_q <= ST_WR_REL;
        ST_WR_REL: begin
          if (!mem_ack_i) begin
            idx_q   <= idx_next;
            state_q <= (idx_next == len_q) ? ST_DONE : ST_READ;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Product held between the read and the write of one element
  always_ff @(posedge clk) begin
    if (en_i && state_q == ST_READ && mem_ack_i) begin
      data_q <= mem_rsp_i.rdata * factor_q;
    end
  end

  // Memory master
  assign mem_req_o        = (state_q == ST_READ) || (state_q == ST_WRITE);
  assign mem_data_o.we    = (state_q == ST_WRITE);
  assign mem_data_o.wdata = data_q;
  assign mem_data_o.addr  = (state_q == ST_WRITE) ?
                            dst_q[`HWPE_AW-1:0] + idx_q[`HWPE_AW-1:0] :
                            src_q[`HWPE_AW-1:0] + idx_q[`HWPE_AW-1:0];

  assign busy_o     = (state_q != ST_IDLE) && (state_q != ST_DONE);
  assign done_evt_o = (state_q == ST_DONE) && en_i;

endmodule

/* src/handshake_mux.sv */
////////////////////////////////////////////////////////////////////////////
// Four-phase channel mux
// Routes one of N_CH req/ack channels to a single channel. The selection
// is locked while the routed req or ack is high, so a select change only
// takes effect once the open transaction has fully closed.
////////////////////////////////////////////////////////////////////////////

module handshake_mux #(
  parameter type         req_t = logic,
  parameter type         rsp_t = logic,
  parameter int unsigned N_CH  = 2
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  hwpe_pkg::sel_t       sel_i,
  // Channel array side
  input  logic [N_CH-1:0]      in_req_i,
  input  req_t [N_CH-1:0]      in_data_i,
  output logic [N_CH-1:0]      in_ack_o,
  output rsp_t [N_CH-1:0]      in_rsp_o,
  // Single channel side
  output logic                 out_req_o,
  output req_t                 out_data_o,
  input  logic                 out_ack_i,
  input  rsp_t                 out_rsp_i
);

  hwpe_pkg::sel_t sel_q;
  hwpe_pkg::sel_t sel_eff;
  logic           open_q;
  logic           open_d;

  // Follow the live select only while nothing is in flight
  assign sel_eff = open_q ? sel_q : sel_i;

  assign out_req_o  = in_req_i[sel_eff];
  assign out_data_o = in_data_i[sel_eff];

  // Transaction stays open until both req and ack are back low
  assign open_d = out_req_o || out_ack_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      open_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      open_q <= open_d;
      sel_q  <= sel_eff;
    end
  end

  // Ack and response reach the locked channel only
  for (genvar i = 0; i < N_CH; i++) begin : gen_ch
    assign in_ack_o[i] = out_ack_i && (sel_eff == hwpe_pkg::sel_t'(i));
    assign in_rsp_o[i] = (sel_eff == hwpe_pkg::sel_t'(i)) ? out_rsp_i : '0;
  end

endmodule

/* src/hwpe_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Accelerator subsystem types
// Payload structs of the configuration and memory channels and the
// engine index shared by the engines, the channel mux and the top
////////////////////////////////////////////////////////////////////////////

`include "hwpe_settings.svh"

package hwpe_pkg;

  // Engine index, 0 is scale and 1 is checksum
  typedef logic [$clog2(`HWPE_N_ENGINES)-1:0] sel_t;

  // Configuration channel, one 32-bit register per access
  typedef struct packed {
    logic [`HWPE_CFG_AW-1:0] addr;
    logic                    we;
    logic [`HWPE_DW-1:0]     wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [`HWPE_DW-1:0] rdata;
  } cfg_rsp_t;

  // Memory channel, word addressed
  typedef struct packed {
    logic [`HWPE_AW-1:0] addr;
    logic                we;
    logic [`HWPE_DW-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`HWPE_DW-1:0] rdata;
  } mem_rsp_t;

endpackage

/* src/hwpe_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Accelerator subsystem settings
// Datapath widths, engine count and the per-engine register map
////////////////////////////////////////////////////////////////////////////

`ifndef HWPE_SETTINGS_SVH
`define HWPE_SETTINGS_SVH

// Widths
`define HWPE_DW        32
`define HWPE_AW        8
`define HWPE_CFG_AW    3

// Engine 0 scales, engine 1 sums
`define HWPE_N_ENGINES 2

// Register offsets, same map in every engine
`define HWPE_REG_SRC    3'd0
`define HWPE_REG_DST    3'd1
`define HWPE_REG_LEN    3'd2
`define HWPE_REG_FACTOR 3'd3
`define HWPE_REG_CTRL   3'd4
`define HWPE_REG_STATUS 3'd5
`define HWPE_REG_RESULT 3'd6

`endif
